/* Bender.yml */
package:
  name: regset

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/regset_pkg.sv
      - hw/regset_ifs.sv
      - hw/spi_sync.sv
      - hw/spi_shifter.sv
      - hw/reg_ctrl.sv
      - hw/reg_bank.sv
      - hw/regset_top.sv
  - target: test
    files:
      - tb/regset_tb.sv

/* hw/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regset_consts.svh"

module reg_bank (
  input  wire                           cs,
  input  wire                           rst,
  reg_access_if.bank                    regs,
  output logic [`REGSET_DATA_BITS-1:0]  reg_led,
  output logic [`REGSET_DATA_BITS-1:0]  reg_spi_mux,
  output logic [`REGSET_DATA_BITS-1:0]  reg_4094,
  output logic [`REGSET_DATA_BITS-1:0]  reg_mode,
  output logic [`REGSET_DATA_BITS-1:0]  reg_direct
);

  localparam int HALF = `REGSET_DATA_BITS / 2;  // update touches the low half only

  logic [`REGSET_DATA_BITS-1:0] rd_mux;

  // new register value for a write or an update
  function automatic logic [`REGSET_DATA_BITS-1:0] next_val(
    input logic [`REGSET_DATA_BITS-1:0] old,
    input logic                         wr,
    input regset_pkg::regset_payload_u  p
  );
    logic [HALF-1:0] both;
    logic [HALF-1:0] low;
    both = p.masks.set & p.masks.clear;  // overlap means toggle
    if (|both)
      low = old[HALF-1:0] ^ both;
    else
      low = (old[HALF-1:0] | p.masks.set) & ~p.masks.clear;  // clear wins
    if (wr)
      next_val = p.value;
    else
      next_val = {old[`REGSET_DATA_BITS-1:HALF], low};  // upper half kept
  endfunction

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      reg_led     <= `REGSET_LED_RESET;
      reg_spi_mux <= '0;  // no spi device selected
      reg_4094    <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
    end
    else if (regs.wr_strobe || regs.upd_strobe)
    begin
      case (regs.addr)
        `REGSET_ADDR_LED:     reg_led     <= next_val(reg_led, regs.wr_strobe, regs.payload);
        `REGSET_ADDR_SPI_MUX: reg_spi_mux <= next_val(reg_spi_mux, regs.wr_strobe,
                                                      regs.payload);
        `REGSET_ADDR_4094:    reg_4094    <= next_val(reg_4094, regs.wr_strobe, regs.payload);
        `REGSET_ADDR_MODE:    reg_mode    <= next_val(reg_mode, regs.wr_strobe, regs.payload);
        `REGSET_ADDR_DIRECT:  reg_direct  <= next_val(reg_direct, regs.wr_strobe, regs.payload);
        default: ;  // unmapped, dropped
      endcase
    end
  end

  // readback, purely combinational on addr
  always_comb
  begin
    case (regs.addr)
      `REGSET_ADDR_LED:     rd_mux = reg_led;
      `REGSET_ADDR_SPI_MUX: rd_mux = reg_spi_mux;
      `REGSET_ADDR_4094:    rd_mux = reg_4094;
      `REGSET_ADDR_MODE:    rd_mux = reg_mode;
      `REGSET_ADDR_DIRECT:  rd_mux = reg_direct;
      default:              rd_mux = `REGSET_READ_DEFAULT;  // recognizable pattern
    endcase
  end

  assign regs.rd_data = rd_mux;

endmodule

`default_nettype wire

/* hw/reg_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regset_consts.svh"

module reg_ctrl (
  input  wire          cs,
  input  wire          rst,
  output logic [7:0]   frame_err_count,
  spi_frame_if.ctrl    frame,
  reg_access_if.ctrl   regs
);

  regset_pkg::regset_cmd_t     cmd_rx;     // command byte as it sits in rx_word
  regset_pkg::regset_cmd_t     cmd_q;      // held for the rest of the frame
  regset_pkg::regset_payload_u payload_q;
  logic                        cmd_hit;    // command byte just completed
  logic                        frame_ok;   // ssn rose after exactly 32 bits
  logic                        frame_bad;  // any other nonzero count
  logic                        wr_q;
  logic                        upd_q;
  logic [7:0]                  err_q;

  // after 8 bits the command is in the low byte
  assign cmd_rx = regset_pkg::regset_cmd_t'(frame.rx_word[`REGSET_CMD_BITS-1:0]);

  assign cmd_hit   = frame.bit_strobe && (frame.bit_count == 6'(`REGSET_CMD_BITS));
  assign frame_ok  = frame.frame_end && (frame.bit_count == 6'(`REGSET_FRAME_BITS));
  assign frame_bad = frame.frame_end && (frame.bit_count != 6'(`REGSET_FRAME_BITS))
                     && (frame.bit_count != 6'd0);

  // addr follows the command in the same cycle so the bank
  // readback is ready for tx_load
  assign regs.addr     = cmd_hit ? cmd_rx.addr : cmd_q.addr;
  assign frame.tx_load = cmd_hit;        // every op replies with the register
  assign frame.tx_word = regs.rd_data;   // unmapped default already applied

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      cmd_q <= '{op: regset_pkg::OP_RSVD, addr: 6'd0};
      wr_q  <= 1'b0;
      upd_q <= 1'b0;
      err_q <= '0;
    end
    else
    begin
      if (frame.frame_start)
        cmd_q <= '{op: regset_pkg::OP_RSVD, addr: 6'd0};  // nothing commits until a command lands
      else if (cmd_hit)
        cmd_q <= cmd_rx;

      // one commit strobe per good frame, none for read or reserved
      wr_q  <= frame_ok && (cmd_q.op == regset_pkg::OP_WRITE);
      upd_q <= frame_ok && (cmd_q.op == regset_pkg::OP_UPDATE);

      if (frame_bad && err_q != 8'hff)
        err_q <= err_q + 8'd1;  // saturating
    end
  end

  // payload is the low 24 bits once the whole frame is in
  always_ff @(posedge cs)
  begin
    if (frame_ok)
      payload_q.value <= frame.rx_word[`REGSET_DATA_BITS-1:0];
  end

  assign regs.wr_strobe  = wr_q;
  assign regs.upd_strobe = upd_q;
  assign regs.payload    = payload_q;
  assign frame_err_count = err_q;

endmodule

`default_nettype wire

/* hw/regset_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regset_consts.svh"

// shifter <-> control, one frame's worth of bits
interface spi_frame_if;

  logic                          bit_strobe;   // one cycle after each sampled bit
  logic [5:0]                    bit_count;    // bits sampled this frame, saturates
  logic [`REGSET_FRAME_BITS-1:0] rx_word;      // newest bit in lsb
  logic                          frame_start;  // ssn fell
  logic                          frame_end;    // ssn rose
  logic                          tx_load;      // load tx_word into tx shifter
  logic [`REGSET_DATA_BITS-1:0]  tx_word;

  modport shifter (
    output bit_strobe, bit_count, rx_word, frame_start, frame_end,
    input  tx_load, tx_word
  );

  modport ctrl (
    input  bit_strobe, bit_count, rx_word, frame_start, frame_end,
    output tx_load, tx_word
  );

endinterface

// control <-> register bank
interface reg_access_if;

  logic                          wr_strobe;   // write payload.value
  logic                          upd_strobe;  // apply payload.masks
  logic [5:0]                    addr;
  regset_pkg::regset_payload_u   payload;
  logic [`REGSET_DATA_BITS-1:0]  rd_data;     // comb readback of addr

  modport ctrl (
    output wr_strobe, upd_strobe, addr, payload,
    input  rd_data
  );

  modport bank (
    input  wr_strobe, upd_strobe, addr, payload,
    output rd_data
  );

endinterface

`default_nettype wire

/* hw/regset_pkg.sv */
`default_nettype none

`include "regset_consts.svh"

package regset_pkg;

  // op field of the command byte
  typedef enum logic [1:0] {
    OP_WRITE  = 2'd0,  // replace register
    OP_UPDATE = 2'd1,  // set/clear masks on low half
    OP_READ   = 2'd2,
    OP_RSVD   = 2'd3   // commits nothing
  } regset_op_e;

  // first byte on the wire
  typedef struct packed {
    regset_op_e op;    // bits 7:6
    logic [5:0] addr;  // bits 5:0
  } regset_cmd_t;

  // update masks, set in the high half
  typedef struct packed {
    logic [`REGSET_DATA_BITS/2-1:0] set;
    logic [`REGSET_DATA_BITS/2-1:0] clear;
  } regset_masks_t;

  // the 24 payload bits, read as a value by a write
  // or as two masks by an update
  typedef union packed {
    logic [`REGSET_DATA_BITS-1:0] value;
    regset_masks_t                masks;
  } regset_payload_u;

endpackage

`default_nettype wire

/* hw/regset_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regset_consts.svh"

module regset_top (
  input  wire                           cs,
  input  wire                           rst,
  input  wire                           sclk,   // from the spi master
  input  wire                           ssn,    // active low frame select
  input  wire                           mosi,
  output logic                          miso,
  output logic [7:0]                    frame_err_count,
  output logic [`REGSET_DATA_BITS-1:0]  reg_led,
  output logic [`REGSET_DATA_BITS-1:0]  reg_spi_mux,
  output logic [`REGSET_DATA_BITS-1:0]  reg_4094,
  output logic [`REGSET_DATA_BITS-1:0]  reg_mode,
  output logic [`REGSET_DATA_BITS-1:0]  reg_direct
);

  // synchronized pins and edge strobes
  logic sclk_fall;
  logic ssn_fall;
  logic ssn_rise;
  logic mosi_s;
  logic ssn_s;

  spi_frame_if  frame_if ();
  reg_access_if regs_if ();

  spi_sync spi_sync_i (
    .cs        (cs),
    .rst       (rst),
    .sclk      (sclk),
    .ssn       (ssn),
    .mosi      (mosi),
    .sclk_fall (sclk_fall),
    .ssn_fall  (ssn_fall),
    .ssn_rise  (ssn_rise),
    .mosi_s    (mosi_s),
    .ssn_s     (ssn_s)
  );

  spi_shifter spi_shifter_i (
    .cs        (cs),
    .rst       (rst),
    .sclk_fall (sclk_fall),
    .ssn_fall  (ssn_fall),
    .ssn_rise  (ssn_rise),
    .mosi_s    (mosi_s),
    .ssn_s     (ssn_s),
    .miso      (miso),
    .frame     (frame_if.shifter)
  );

  reg_ctrl reg_ctrl_i (
    .cs              (cs),
    .rst             (rst),
    .frame_err_count (frame_err_count),
    .frame           (frame_if.ctrl),
    .regs            (regs_if.ctrl)
  );

  reg_bank reg_bank_i (
    .cs          (cs),
    .rst         (rst),
    .regs        (regs_if.bank),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct)
  );

endmodule

`default_nettype wire

/* hw/spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regset_consts.svh"

module spi_shifter (
  input  wire          cs,
  input  wire          rst,
  input  wire          sclk_fall,
  input  wire          ssn_fall,
  input  wire          ssn_rise,
  input  wire          mosi_s,
  input  wire          ssn_s,
  output logic         miso,
  spi_frame_if.shifter frame
);

  logic [`REGSET_FRAME_BITS-1:0] rx_q;     // receive shifter
  logic [`REGSET_DATA_BITS-1:0]  tx_q;     // transmit shifter, msb on miso
  logic [5:0]                    cnt_q;    // bits this frame
  logic                          bit_q;
  logic                          start_q;
  logic                          end_q;
  logic                          sample;   // a valid sclk fall inside a frame
  logic                          tx_shift;

  assign sample   = sclk_fall & ~ssn_s;
  // reply bits start after the command byte
  assign tx_shift = sample & (cnt_q >= 6'(`REGSET_CMD_BITS));

  // counter and strobes
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      cnt_q   <= '0;
      bit_q   <= 1'b0;
      start_q <= 1'b0;
      end_q   <= 1'b0;
    end
    else
    begin
      if (ssn_fall)
        cnt_q <= '0;
      else if (sample && cnt_q != 6'd63)
        cnt_q <= cnt_q + 6'd1;  // sticks at 63, overlong frames stay wrong
      bit_q   <= sample;        // count already updated when this is seen
      start_q <= ssn_fall;
      end_q   <= ssn_rise;
    end
  end

  // data shifters, cleared per frame
  always_ff @(posedge cs)
  begin
    if (ssn_fall)
      rx_q <= '0;
    else if (sample)
      rx_q <= {rx_q[`REGSET_FRAME_BITS-2:0], mosi_s};

    if (ssn_fall)
      tx_q <= '0;
    else if (frame.tx_load)
      tx_q <= frame.tx_word;  // readback, lands between bit 8 and bit 9
    else if (tx_shift)
      tx_q <= {tx_q[`REGSET_DATA_BITS-2:0], 1'b0};
  end

  assign miso = ssn_s ? 1'b0 : tx_q[`REGSET_DATA_BITS-1];  // quiet outside a frame

  assign frame.bit_strobe  = bit_q;
  assign frame.bit_count   = cnt_q;
  assign frame.rx_word     = rx_q;
  assign frame.frame_start = start_q;
  assign frame.frame_end   = end_q;

endmodule

`default_nettype wire

/* hw/spi_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regset_consts.svh"

module spi_sync (
  input  wire  cs,
  input  wire  rst,
  input  wire  sclk,
  input  wire  ssn,
  input  wire  mosi,
  output logic sclk_fall,  // one cycle strobes stages+1 after the pin edge
  output logic ssn_fall,
  output logic ssn_rise,
  output logic mosi_s,
  output logic ssn_s
);

  // line order {sclk, ssn, mosi}; ssn idles high
  localparam logic [2:0] IDLE = 3'b010;

  logic [`REGSET_SYNC_STAGES-1:0][2:0] sync_q;  // stage 0 sees the pins
  logic [2:0]                          last;    // synchronized lines
  logic [2:1]                          prev_q;  // sclk and ssn one cycle older

  assign last = sync_q[`REGSET_SYNC_STAGES-1];

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sync_q    <= {`REGSET_SYNC_STAGES{IDLE}};  // no false ssn edge after a mid-frame reset
      prev_q    <= IDLE[2:1];
      sclk_fall <= 1'b0;
      ssn_fall  <= 1'b0;
      ssn_rise  <= 1'b0;
    end
    else
    begin
      sync_q    <= {sync_q[`REGSET_SYNC_STAGES-2:0], {sclk, ssn, mosi}};
      prev_q    <= last[2:1];
      sclk_fall <= prev_q[2] & ~last[2];
      ssn_fall  <= prev_q[1] & ~last[1];
      ssn_rise  <= ~prev_q[1] & last[1];
    end
  end

  assign ssn_s  = last[1];
  assign mosi_s = last[0];  // settled well before the fall strobe

endmodule

`default_nettype wire

/* include/regset_consts.svh */
`ifndef REGSET_CONSTS_SVH
`define REGSET_CONSTS_SVH

// frame layout, msb first: command byte then payload
`define REGSET_FRAME_BITS    32
`define REGSET_CMD_BITS      8
`define REGSET_DATA_BITS     24   // register and payload width

// flops per synchronizer line
`define REGSET_SYNC_STAGES   2

// register map, 6-bit addresses
`define REGSET_ADDR_LED      6'd7
`define REGSET_ADDR_SPI_MUX  6'd8
`define REGSET_ADDR_4094     6'd9
`define REGSET_ADDR_MODE     6'd12
`define REGSET_ADDR_DIRECT   6'd14

// reset and default values
`define REGSET_LED_RESET     24'haaaaaa  // alternating pattern, easy to spot on the leds
`define REGSET_READ_DEFAULT  24'h0f0f0f  // unmapped reads

`endif

/* project.f */
+incdir+include
hw/regset_pkg.sv
hw/regset_ifs.sv
hw/spi_sync.sv
hw/spi_shifter.sv
hw/reg_ctrl.sv
hw/reg_bank.sv
hw/regset_top.sv
tb/regset_tb.sv

/* tb/regset_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module regset_tb;

  localparam int NUM_FRAMES = 208;  // 64 reads, 40 writes, 40 updates, 40 rw, 24 bad/rsvd
  localparam int CYCLE_LIMIT = (NUM_FRAMES * 32 * 12 + NUM_FRAMES * 10) * 12 / 10;
  localparam logic [23:0] LED_RESET    = 24'haaaaaa;
  localparam logic [23:0] READ_DEFAULT = 24'h0f0f0f;  // unmapped reply

  logic        cs;
  logic        rst;
  logic        sclk;
  logic        ssn;
  logic        mosi;
  wire         miso;
  wire  [7:0]  frame_err_count;
  wire  [23:0] reg_led;
  wire  [23:0] reg_spi_mux;
  wire  [23:0] reg_4094;
  wire  [23:0] reg_mode;
  wire  [23:0] reg_direct;

  logic [23:0] model_regs [0:4];  // led, spi_mux, 4094, mode, direct
  int          model_errs;        // expected frame_err_count
  integer      seed;
  int          pass_count;
  int          fail_count;
  int          cycle_count;

  regset_top regset_top_i (
    .cs              (cs),
    .rst             (rst),
    .sclk            (sclk),
    .ssn             (ssn),
    .mosi            (mosi),
    .miso            (miso),
    .frame_err_count (frame_err_count),
    .reg_led         (reg_led),
    .reg_spi_mux     (reg_spi_mux),
    .reg_4094        (reg_4094),
    .reg_mode        (reg_mode),
    .reg_direct      (reg_direct)
  );

  initial
  begin
    cs = 1'b0;
    forever #50 cs = ~cs;  // 100 ns period
  end

  // watchdog on the whole run
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge cs);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  // model register map with -1 for unmapped
  function automatic int reg_index(input logic [5:0] addr);
    case (addr)
      6'd7:    return 0;
      6'd8:    return 1;
      6'd9:    return 2;
      6'd12:   return 3;
      6'd14:   return 4;
      default: return -1;
    endcase
  endfunction

  function automatic logic [23:0] model_read(input logic [5:0] addr);
    int idx;
    idx = reg_index(addr);
    return (idx < 0) ? READ_DEFAULT : model_regs[idx];
  endfunction

  // overlap toggles, otherwise set then clear
  function automatic logic [23:0] apply_update(input logic [23:0] old, input logic [11:0] set,
                                               input logic [11:0] clr);
    logic [11:0] low;
    low = old[11:0];
    if ((set & clr) != 12'h000)
      low = low ^ (set & clr);
    else
    begin
      low = low | set;
      low = low & ~clr;  // clear has the last word
    end
    return {old[23:12], low};  // upper half untouched
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge cs);
    #10;  // inputs move after the edge
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      fail_count++;
    end
    else
      pass_count++;
  endtask

  task automatic check_ports();
    check("reg_led", reg_led, model_regs[0]);
    check("reg_spi_mux", reg_spi_mux, model_regs[1]);
    check("reg_4094", reg_4094, model_regs[2]);
    check("reg_mode", reg_mode, model_regs[3]);
    check("reg_direct", reg_direct, model_regs[4]);
    check("frame_err_count", frame_err_count, model_errs);
    check("miso", miso, 1'b0);  // idle while ssn is high
  endtask

  // bit-level master; bits past 32 go out as zeros
  task automatic send_frame(input logic [31:0] word, input int nbits, output logic [23:0] reply);
    int i;
    reply = 24'h0;
    ssn   = 1'b0;
    tick(6);
    for (i = 0; i < nbits; i++)
    begin
      sclk = 1'b1;
      mosi = (i < 32) ? word[31 - i] : 1'b0;  // msb first
      tick(6);
      if (i >= 8 && i < 32)
        reply = {reply[22:0], miso};  // reply bits 9..32
      sclk = 1'b0;                    // dut samples on this fall
      tick(6);
    end
    ssn  = 1'b1;
    mosi = 1'b0;
    tick(10);  // commit needs 6 of these
  endtask

  // about half the picks are mapped addresses
  task automatic pick_addr(output logic [5:0] addr);
    logic [31:0] r;
    int          sel;
    r   = $random(seed);
    sel = r[7:1] % 5;
    if (r[0])
      case (sel)
        0:       addr = 6'd7;
        1:       addr = 6'd8;
        2:       addr = 6'd9;
        3:       addr = 6'd12;
        default: addr = 6'd14;
      endcase
    else
      addr = r[13:8];
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [23:0] data);
    logic [23:0] reply;
    int          idx;
    send_frame({2'd0, addr, data}, 32, reply);
    check("miso reply", reply, model_read(addr));  // old value comes back
    idx = reg_index(addr);
    if (idx >= 0)
      model_regs[idx] = data;
    check_ports();
  endtask

  task automatic update_reg(input logic [5:0] addr, input logic [11:0] set,
                            input logic [11:0] clr);
    logic [23:0] reply;
    int          idx;
    send_frame({2'd1, addr, set, clr}, 32, reply);
    check("miso reply", reply, model_read(addr));
    idx = reg_index(addr);
    if (idx >= 0)
      model_regs[idx] = apply_update(model_regs[idx], set, clr);
    check_ports();
  endtask

  task automatic read_reg(input logic [5:0] addr);
    logic [23:0] reply;
    send_frame({2'd2, addr, 24'h000000}, 32, reply);
    check("miso reply", reply, model_read(addr));
    check_ports();
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("test %s: %s, %0d failed checks", name,
             (fail_count == fails_before) ? "ok" : "wrong", fail_count - fails_before);
  endtask

  initial
  begin
    logic [23:0] reply;
    logic [31:0] r;
    logic [5:0]  addr;
    logic [11:0] set;
    logic [11:0] clr;
    int          fails_at;
    int          len;
    int          k;
    int          i;
    seed       = 32'hda7b;
    pass_count = 0;
    fail_count = 0;
    model_errs = 0;
    rst  = 1'b1;
    sclk = 1'b0;  // idles low
    ssn  = 1'b1;
    mosi = 1'b0;
    model_regs[0] = LED_RESET;
    for (i = 1; i < 5; i++)
      model_regs[i] = 24'h000000;
    repeat (10) @(posedge cs);
    #10;
    rst = 1'b0;
    tick(2);

    fails_at = fail_count;
    check_ports();
    for (i = 0; i < 64; i++)
      read_reg(6'(i));  // whole address space
    report_test("reset values", fails_at);

    fails_at = fail_count;
    for (i = 0; i < 40; i++)
    begin
      pick_addr(addr);
      r = $random(seed);
      write_reg(addr, r[23:0]);
    end
    report_test("random writes", fails_at);

    fails_at = fail_count;
    for (i = 0; i < 40; i++)
    begin
      pick_addr(addr);
      r   = $random(seed);
      set = r[11:0];
      clr = r[23:12];
      if (r[24])
        clr = clr & ~set;  // disjoint masks
      else
      begin
        k      = r[28:25] % 12;  // force one shared bit
        set[k] = 1'b1;
        clr[k] = 1'b1;
      end
      update_reg(addr, set, clr);
    end
    report_test("random updates", fails_at);

    fails_at = fail_count;
    for (i = 0; i < 20; i++)
    begin
      pick_addr(addr);
      r = $random(seed);
      write_reg(addr, r[23:0]);
      read_reg(addr);
    end
    report_test("readback", fails_at);

    fails_at = fail_count;
    for (i = 0; i < 20; i++)
    begin
      r   = $random(seed);
      len = 1 + r[15:0] % 40;
      if (len == 32)
        len = 31;
      pick_addr(addr);
      r = $random(seed);
      send_frame({2'd0, addr, r[23:0]}, len, reply);
      if (model_errs < 255)
        model_errs++;
      check_ports();  // nothing committed
    end
    for (i = 0; i < 4; i++)
    begin
      pick_addr(addr);
      r = $random(seed);
      send_frame({2'd3, addr, r[23:0]}, 32, reply);  // reserved op
      check("miso reply", reply, model_read(addr));
      check_ports();
    end
    report_test("framing errors", fails_at);

    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
